/* pifo_pkg.sv */
package pifo_pkg;

    //////////////////////////////////////////////////
    // entry widths
    //////////////////////////////////////////////////

    // rank decides the order, lower leaves first
    localparam int rank_w = 16;
    localparam int field_w = 11;

    // calendar depth used when the top level sets nothing else
    localparam int default_depth = 16;

    //////////////////////////////////////////////////
    // calendar entry
    //////////////////////////////////////////////////

    // {valid, rank, field} in 28 bits
    typedef struct packed {
        logic               valid;
        logic [rank_w-1:0]  rank;
        logic [field_w-1:0] field;
    } pifo_entry_t;

    //////////////////////////////////////////////////
    // operation decoded per cycle
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_idle,
        op_insert,
        op_pop,
        // head leaves, new entry placed in order
        op_pop_insert,
        // new entry goes straight to the output
        op_bypass
    } pifo_op_e;

endpackage

/* pifo_insert_locator.sv */
`timescale 1ns/10ps

module pifo_insert_locator #(
    parameter int DEPTH = pifo_pkg::default_depth,
    // one extra code so that "behind the last entry" can be named
    localparam int idx_w = $clog2(DEPTH + 1)
) (
    input  logic                                 insert_en,
    input  logic [pifo_pkg::rank_w-1:0]          insert_rank,
    input  logic [pifo_pkg::field_w-1:0]         insert_field,
    input  logic                                 pop_en,
    input  pifo_pkg::pifo_entry_t [DEPTH-1:0]    entries,
    output pifo_pkg::pifo_op_e                   op,
    output logic [idx_w-1:0]                     slot,
    output pifo_pkg::pifo_entry_t                new_entry
);

    // one bit per slot, set where the new entry would sit in front
    logic [DEPTH-1:0] cmp;

    //////////////////////////////////////////////////
    // comparator array
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            // strict compare keeps ties behind the older entries
            cmp[i] = (insert_rank < entries[i].rank) || !entries[i].valid;
        end
    end

    //////////////////////////////////////////////////
    // priority encoder
    //////////////////////////////////////////////////

    // lowest set bit wins, no bit set means past the tail
    always_comb
    begin
        slot = idx_w'(DEPTH);
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (cmp[i])
            begin
                slot = idx_w'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // operation decode
    //////////////////////////////////////////////////

    always_comb
    begin
        new_entry.valid = insert_en;
        new_entry.rank = insert_rank;
        new_entry.field = insert_field;
    end

    always_comb
    begin
        op = pifo_pkg::op_idle;
        if (pop_en && insert_en)
        begin
            // slot 0 covers both a smaller rank and an empty calendar
            if (slot == '0)
            begin
                op = pifo_pkg::op_bypass;
            end
            else
            begin
                op = pifo_pkg::op_pop_insert;
            end
        end
        else if (insert_en)
        begin
            op = pifo_pkg::op_insert;
        end
        else if (pop_en && entries[0].valid)
        begin
            op = pifo_pkg::op_pop;
        end
    end

endmodule

/* pifo_calendar.sv */
`timescale 1ns/10ps

module pifo_calendar #(
    parameter int DEPTH = pifo_pkg::default_depth,
    localparam int idx_w = $clog2(DEPTH + 1)
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  pifo_pkg::pifo_op_e                   op,
    input  logic [idx_w-1:0]                     slot,
    input  pifo_pkg::pifo_entry_t                new_entry,
    output pifo_pkg::pifo_entry_t [DEPTH-1:0]    entries,
    output pifo_pkg::pifo_entry_t                head,
    output logic                                 empty
);

    // next calendar contents
    pifo_pkg::pifo_entry_t [DEPTH-1:0] entries_nxt;

    //////////////////////////////////////////////////
    // shift and write per opcode
    //////////////////////////////////////////////////

    always_comb
    begin
        int unsigned slot_n;

        slot_n = slot;
        entries_nxt = entries;

        case (op)
            pifo_pkg::op_insert:
            begin
                for (int i = 0; i < DEPTH; i++)
                begin
                    // open a gap at slot, tail side moves back
                    if (i == slot_n)
                    begin
                        entries_nxt[i] = new_entry;
                    end
                    else if (i > slot_n)
                    begin
                        entries_nxt[i] = entries[i-1];
                    end
                end
            end

            pifo_pkg::op_pop:
            begin
                for (int i = 0; i < DEPTH - 1; i++)
                begin
                    entries_nxt[i] = entries[i+1];
                end
                entries_nxt[DEPTH-1] = '0;
            end

            pifo_pkg::op_pop_insert:
            begin
                // head leaves, front part closes up onto the new entry
                for (int i = 0; i < DEPTH - 1; i++)
                begin
                    if (i + 1 < slot_n)
                    begin
                        entries_nxt[i] = entries[i+1];
                    end
                    else if (i + 1 == slot_n)
                    begin
                        entries_nxt[i] = new_entry;
                    end
                end
                // full calendar with the new rank behind every entry
                if (slot_n == DEPTH)
                begin
                    entries_nxt[DEPTH-1] = new_entry;
                end
            end

            // bypass and idle leave the calendar alone
            default:
            begin
                entries_nxt = entries;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // calendar registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rstn)
        begin
            entries <= '0;
        end
        else
        begin
            entries <= entries_nxt;
        end
    end

    assign head = entries[0];
    // sorted with no gaps, so an invalid head means nothing stored
    assign empty = !entries[0].valid;

endmodule

/* pifo_pop_stage.sv */
`timescale 1ns/10ps

module pifo_pop_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  pifo_pkg::pifo_op_e           op,
    input  pifo_pkg::pifo_entry_t        head,
    input  pifo_pkg::pifo_entry_t        new_entry,
    output logic                         out_valid,
    output logic [pifo_pkg::rank_w-1:0]  out_rank,
    output logic [pifo_pkg::field_w-1:0] out_field,
    output logic                         insert_credit
);

    logic                  pop_sel;
    logic                  pop_done;
    pifo_pkg::pifo_entry_t out_src;

    // every opcode that sends an entry out
    assign pop_sel = (op == pifo_pkg::op_pop) || (op == pifo_pkg::op_pop_insert) ||
                     (op == pifo_pkg::op_bypass);

    // bypass takes the incoming entry, the rest take the head
    assign out_src = (op == pifo_pkg::op_bypass) ? new_entry : head;

    always_ff @(posedge clk)
    begin
        if (pop_sel)
        begin
            out_rank <= out_src.rank;
            out_field <= out_src.field;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rstn)
        begin
            pop_done <= 1'b0;
        end
        else
        begin
            pop_done <= pop_sel;
        end
    end

    // one slot freed per entry sent out
    assign out_valid = pop_done;
    assign insert_credit = pop_done;

endmodule

/* pifo_top.sv */
`timescale 1ns/10ps

module pifo_top #(
    parameter int DEPTH = pifo_pkg::default_depth
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         insert_en,
    input  logic [pifo_pkg::rank_w-1:0]  insert_rank,
    input  logic [pifo_pkg::field_w-1:0] insert_field,
    input  logic                         pop_en,
    output logic                         out_valid,
    output logic [pifo_pkg::rank_w-1:0]  out_rank,
    output logic [pifo_pkg::field_w-1:0] out_field,
    output logic                         insert_credit,
    output logic                         empty
);

    localparam int idx_w = $clog2(DEPTH + 1);

    pifo_pkg::pifo_entry_t [DEPTH-1:0] entries;
    pifo_pkg::pifo_entry_t             head;
    pifo_pkg::pifo_entry_t             new_entry;
    pifo_pkg::pifo_op_e                op;
    logic [idx_w-1:0]                  slot;

    //////////////////////////////////////////////////
    // decode and placement, same cycle
    //////////////////////////////////////////////////

    pifo_insert_locator #(
        .DEPTH(DEPTH)
    ) locator_i (
        .insert_en(insert_en),
        .insert_rank(insert_rank),
        .insert_field(insert_field),
        .pop_en(pop_en),
        .entries(entries),
        .op(op),
        .slot(slot),
        .new_entry(new_entry)
    );

    pifo_calendar #(
        .DEPTH(DEPTH)
    ) calendar_i (
        .clk(clk),
        .rstn(rstn),
        .op(op),
        .slot(slot),
        .new_entry(new_entry),
        .entries(entries),
        .head(head),
        .empty(empty)
    );

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    pifo_pop_stage pop_stage_i (
        .clk(clk),
        .rstn(rstn),
        .op(op),
        .head(head),
        .new_entry(new_entry),
        .out_valid(out_valid),
        .out_rank(out_rank),
        .out_field(out_field),
        .insert_credit(insert_credit)
    );

endmodule

/* tb_pifo_assertions.sv */
`timescale 1ns/10ps

module tb_pifo_assertions (
    input logic clk,
    input logic rstn,
    input logic insert_en,
    input logic pop_en,
    input logic empty,
    input logic full,
    input logic out_valid,
    input logic insert_credit
);

    logic legal_pop;
    logic fail_seen;
    bit   reset_bad;
    bit   late_bad;
    bit   extra_bad;
    bit   credit_bad;
    bit   room_bad;

    // something can leave, either stored or bypassed
    assign legal_pop = pop_en && (!empty || insert_en);
    assign fail_seen = reset_bad | late_bad | extra_bad | credit_bad | room_bad;

    //////////////////////////////////////////////////
    // reset state
    //////////////////////////////////////////////////

    reset_idle: assert property (
        @(posedge clk) rstn |=> (empty && !out_valid && !insert_credit))
    else
    begin
        reset_bad = 1'b1;
        $error("outputs not idle after reset");
    end

    //////////////////////////////////////////////////
    // output timing
    //////////////////////////////////////////////////

    pop_gives_output: assert property (
        @(posedge clk) disable iff (rstn) legal_pop |=> out_valid)
    else
    begin
        late_bad = 1'b1;
        $error("pop accepted but no output in the next cycle");
    end

    // out_valid only right after a pop, so one cycle per pop
    output_needs_pop: assert property (
        @(posedge clk) disable iff (rstn) !legal_pop |=> !out_valid)
    else
    begin
        extra_bad = 1'b1;
        $error("output seen without a pop in the cycle before");
    end

    //////////////////////////////////////////////////
    // credits
    //////////////////////////////////////////////////

    credit_per_output: assert property (
        @(posedge clk) disable iff (rstn) insert_credit == out_valid)
    else
    begin
        credit_bad = 1'b1;
        $error("credit return does not match the output");
    end

    // a full calendar only takes an insert paired with a pop
    insert_has_room: assert property (
        @(posedge clk) disable iff (rstn) (full && insert_en) |-> pop_en)
    else
    begin
        room_bad = 1'b1;
        $error("insert issued into a full calendar");
    end

endmodule

/* tb_pifo.sv */
`timescale 1ns/10ps

module tb_pifo;

    localparam int DEPTH = pifo_pkg::default_depth;
    localparam int rank_w = pifo_pkg::rank_w;
    localparam int n_random = 12;
    localparam int n_mix = 80;
    // reset, random fill and drain, full fill and drain, directed cases, mix, margin
    localparam int cycle_limit = 2 + (2 * n_random + 4) + (2 * DEPTH + 4) + 16 +
                                 (n_mix + DEPTH + 6) + 50;

    logic                         clk;
    logic                         rstn;
    logic                         insert_en;
    logic [rank_w-1:0]            insert_rank;
    logic [pifo_pkg::field_w-1:0] insert_field;
    logic                         pop_en;
    logic                         out_valid;
    logic [rank_w-1:0]            out_rank;
    logic [pifo_pkg::field_w-1:0] out_field;
    logic                         insert_credit;
    logic                         empty;

    // sorted by rank, ties in arrival order
    pifo_pkg::pifo_entry_t model_q[$];
    // entries still owed by the DUT, oldest first
    pifo_pkg::pifo_entry_t expect_q[$];
    int credits = DEPTH;
    int seq = 0;
    int cycle_cnt = 0;

    pifo_top #(.DEPTH(DEPTH)) dut_i (.*);

    bind pifo_top tb_pifo_assertions assertions_i (
        .clk(clk),
        .rstn(rstn),
        .insert_en(insert_en),
        .pop_en(pop_en),
        .empty(empty),
        .full(entries[DEPTH-1].valid),
        .out_valid(out_valid),
        .insert_credit(insert_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    // one operation for one cycle, model updated the same way
    task automatic issue(input logic ins, input logic [rank_w-1:0] rank, input logic pop);
        pifo_pkg::pifo_entry_t e;
        int pos;
        logic place;
        e.valid = 1'b1;
        e.rank = rank;
        e.field = pifo_pkg::field_w'(seq);
        pos = 0;
        place = ins;
        if (ins)
        begin
            assert (credits > 0) else stop_on_failure("insert attempted with no credit left");
            credits--;
            seq++;
        end
        if (pop)
        begin
            assert (ins || model_q.size() > 0)
                else stop_on_failure("pop attempted on an empty calendar");
            // new entry only jumps ahead with a strictly smaller rank
            if (ins && (model_q.size() == 0 || rank < model_q[0].rank))
            begin
                expect_q.push_back(e);
                place = 1'b0;
            end
            else
            begin
                expect_q.push_back(model_q.pop_front());
            end
        end
        if (place)
        begin
            while (pos < model_q.size() && model_q[pos].rank <= rank)
                pos++;
            model_q.insert(pos, e);
        end
        insert_en = ins;
        insert_rank = rank;
        insert_field = e.field;
        pop_en = pop;
        @(posedge clk);
        #1;
        insert_en = 1'b0;
        pop_en = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // back-to-back pops, then wait for the last outputs
    task automatic drain();
        while (model_q.size() > 0)
            issue(1'b0, '0, 1'b1);
        while (expect_q.size() > 0)
            idle(1);
        idle(2);
    endtask

    //////////////////////////////////////////////////
    // output and credit monitor
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        pifo_pkg::pifo_entry_t want;
        if (insert_credit)
            credits++;
        assert (credits <= DEPTH) else stop_on_failure("credit count rose above DEPTH");
        if (out_valid)
        begin
            assert (expect_q.size() > 0) else stop_on_failure("output with no pending pop");
            want = expect_q.pop_front();
            assert (out_rank == want.rank)
                else stop_on_failure($sformatf("** Error: out_rank = %h, expected %h",
                                               out_rank, want.rank));
            assert (out_field == want.field)
                else stop_on_failure($sformatf("** Error: out_field = %h, expected %h",
                                               out_field, want.field));
        end
        assert (!dut_i.assertions_i.fail_seen)
            else stop_on_failure("a bound protocol assertion failed");
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
            stop_on_failure("timeout, the run took more cycles than its tests need");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial
    begin
        logic ins;
        logic pop;
        void'($urandom(89));
        rstn = 1'b1;
        insert_en = 1'b0;
        insert_rank = '0;
        insert_field = '0;
        pop_en = 1'b0;
        idle(2);
        rstn = 1'b0;
        idle(1);

        // narrow rank range so ties are common
        repeat (n_random)
            issue(1'b1, rank_w'($urandom_range(7, 0)), 1'b0);
        drain();
        assert (credits == DEPTH) else stop_on_failure("credits not all returned after drain");

        // fill until the credits run out
        while (credits > 0)
            issue(1'b1, rank_w'($urandom_range(15, 0)), 1'b0);
        assert (!empty && dut_i.entries[DEPTH-1].valid)
            else stop_on_failure("calendar not full after spending every credit");
        drain();
        assert (credits == DEPTH) else stop_on_failure("credits not all returned after fill");

        // pop and insert, bypass, tie with the head, then sorted placement
        issue(1'b1, 16'd20, 1'b0);
        issue(1'b1, 16'd30, 1'b0);
        issue(1'b1, 16'd40, 1'b0);
        issue(1'b1, 16'd5, 1'b1);
        assert (model_q.size() == 3 && dut_i.entries[2].valid && !dut_i.entries[3].valid)
            else stop_on_failure("bypass changed the occupancy");
        issue(1'b1, 16'd20, 1'b1);
        issue(1'b1, 16'd35, 1'b1);
        drain();
        issue(1'b1, 16'd9, 1'b1);

        repeat (n_mix)
        begin
            ins = (credits > 0) && ($urandom_range(1, 0) == 1);
            pop = ($urandom_range(2, 0) == 0) && (ins || model_q.size() > 0);
            issue(ins, rank_w'($urandom_range(7, 0)), pop);
        end
        drain();

        if (expect_q.size() == 0 && credits == DEPTH && !dut_i.assertions_i.fail_seen)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            stop_on_failure("outputs or credits missing at the end of the run");
        end
    end

endmodule

/* flist.f */
pifo_pkg.sv
pifo_insert_locator.sv
pifo_calendar.sv
pifo_pop_stage.sv
pifo_top.sv
tb_pifo_assertions.sv
tb_pifo.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_pifo
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+10

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
